/* rtl/fb_pkg.sv */
package fb_pkg;

    //////////////////////////////////////////////////
    // basic widths
    //////////////////////////////////////////////////

    localparam int ADDR_W       = 28;           // memory address, pixel units
    localparam int PIX_W        = 16;           // rgb565 style pixel
    localparam int PIX_PER_WORD = 8;            // pixels per memory word
    localparam int WORD_W       = PIX_W * PIX_PER_WORD;
    localparam int LEN_W        = 8;            // burst length field
    localparam int SIZE_W       = 12;           // window width / height fields
    localparam int NUM_CH       = 4;            // video input channels

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [PIX_W-1:0]  pix_t;
    typedef logic [WORD_W-1:0] word_t;          // first pixel in the low bits
    typedef logic [LEN_W-1:0]  len_t;           // burst length in words

    //////////////////////////////////////////////////
    // layout mode select, one-hot
    //////////////////////////////////////////////////

    typedef logic [4:0] mode_t;

    localparam mode_t MODE_QUAD    = 5'b10000;  // 2x2 mosaic
    localparam mode_t MODE_SINGLE0 = 5'b01000;  // ch0 full screen
    localparam mode_t MODE_SINGLE1 = 5'b00100;  // ch1 full screen
    localparam mode_t MODE_SINGLE2 = 5'b00010;  // ch2 full screen
    localparam mode_t MODE_SINGLE3 = 5'b00001;  // ch3 full screen

    //////////////////////////////////////////////////
    // bundled signals
    //////////////////////////////////////////////////

    // one video input channel, 18 bits
    typedef struct packed {
        logic fsync;                            // frame start
        logic en;                               // pixel valid
        pix_t data;
    } video_in_t;

    // placement of one channel in the frame, 53 bits
    typedef struct packed {
        logic              enable;              // channel takes video
        logic [SIZE_W-1:0] h_num;               // window width, pixels
        logic [SIZE_W-1:0] v_num;               // window height, lines
        addr_t             offset;              // window origin in memory
    } chan_layout_t;

    // write command to the memory controller, 36 bits
    typedef struct packed {
        addr_t addr;                            // first pixel of the burst
        len_t  len;                             // words in the burst
    } wr_cmd_t;

endpackage

/* rtl/layout_decoder.sv */
module layout_decoder
    import fb_pkg::*;
#(
    parameter int H_ACT = 1280,                 // full frame width
    parameter int V_ACT = 720                   // full frame height
) (
    input  logic                       ddr_clk,
    input  logic                       ddr_rstn,
    input  mode_t                      mode,
    output chan_layout_t [NUM_CH-1:0]  layout
);

    localparam int    H_WIN     = H_ACT / 2;    // mosaic window width
    localparam int    V_WIN     = V_ACT / 2;    // mosaic window height
    localparam addr_t LOWER_OFS = addr_t'(V_WIN * H_ACT);   // start of lower half

    // full screen placement at the frame origin
    localparam chan_layout_t FULL_CH = '{
        enable : 1'b1,
        h_num  : SIZE_W'(H_ACT),
        v_num  : SIZE_W'(V_ACT),
        offset : '0
    };

    chan_layout_t [NUM_CH-1:0] layout_nxt;      // decoded placement

    always_comb begin
        layout_nxt = '0;                        // default all channels off
        case (mode)
            MODE_QUAD: begin
                for (int i = 0; i < NUM_CH; i++) begin
                    layout_nxt[i].enable = 1'b1;
                    layout_nxt[i].h_num  = SIZE_W'(H_WIN);
                    layout_nxt[i].v_num  = SIZE_W'(V_WIN);
                end
                layout_nxt[1].offset = addr_t'(H_WIN);              // top right
                layout_nxt[2].offset = LOWER_OFS;                   // bottom left
                layout_nxt[3].offset = LOWER_OFS + addr_t'(H_WIN);  // bottom right
            end
            MODE_SINGLE0: layout_nxt[0] = FULL_CH;
            MODE_SINGLE1: layout_nxt[1] = FULL_CH;
            MODE_SINGLE2: layout_nxt[2] = FULL_CH;
            MODE_SINGLE3: layout_nxt[3] = FULL_CH;
            default: ;                          // not one-hot, nothing enabled
        endcase
    end

    always_ff @(posedge ddr_clk) begin
        if (!ddr_rstn) begin
            layout <= '0;                       // every enable low after reset
        end else begin
            layout <= layout_nxt;               // valid one cycle after mode
        end
    end

endmodule

/* rtl/channel_writer.sv */
module channel_writer
    import fb_pkg::*;
#(
    parameter int H_ACT       = 1280,           // frame line pitch
    parameter int BURST_WORDS = 4,              // words per burst
    parameter int FIFO_BURSTS = 2               // bursts held in the FIFO
) (
    input  logic         ddr_clk,
    input  logic         ddr_rstn,
    input  video_in_t    video,
    input  chan_layout_t layout,
    input  logic         wdata_req_ch,          // pop already gated by grant
    input  logic         wdone_ch,              // burst written
    output logic         wreq_ch,
    output wr_cmd_t      cmd_rel,               // address relative to window
    output word_t        wdata_ch               // FIFO head word
);

    localparam int DEPTH     = BURST_WORDS * FIFO_BURSTS;
    localparam int PTR_W     = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W     = $clog2(DEPTH + 1);
    localparam int BEAT_W    = (BURST_WORDS > 1) ? $clog2(BURST_WORDS) : 1;
    localparam int BCNT_W    = $clog2(FIFO_BURSTS + 1);
    localparam int PIX_IDX_W = $clog2(PIX_PER_WORD);
    localparam int LOW_W     = WORD_W - PIX_W;  // seven packed pixels
    localparam logic [SIZE_W-1:0] COL_STEP = SIZE_W'(BURST_WORDS * PIX_PER_WORD);

    logic                 clr;                  // fsync or channel off
    logic                 pix_ok;               // pixel accepted this cycle
    logic                 push;                 // eighth pixel completes a word
    logic                 pop;
    logic                 burst_in;             // last word of a burst stored
    logic                 retire;               // burst done frees its slot
    logic                 fifo_full;
    logic [PIX_IDX_W-1:0] pix_idx;              // slot of next pixel in word
    logic [LOW_W-1:0]     pack_q;               // first seven pixels of a word
    word_t                fifo_mem [DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     fifo_cnt;             // words in FIFO
    logic [BEAT_W-1:0]    wr_beat;              // words stored in open burst
    logic [BCNT_W-1:0]    burst_cnt;            // whole bursts not yet retired
    logic                 sending;              // head burst on the bus
    logic [SIZE_W-1:0]    col_q;                // first column of next burst
    logic [SIZE_W-1:0]    line_q;               // line of next burst
    logic [SIZE_W-1:0]    col_nxt;
    logic                 col_wrap;
    logic                 line_wrap;

    //////////////////////////////////////////////////
    // pixel packing
    //////////////////////////////////////////////////

    assign clr       = video.fsync || !layout.enable;
    assign fifo_full = (fifo_cnt == CNT_W'(DEPTH));
    assign pix_ok    = video.en && !clr && !fifo_full;      // drop when full
    assign push      = pix_ok && (pix_idx == PIX_IDX_W'(PIX_PER_WORD - 1));

    always_ff @(posedge ddr_clk) begin
        if (pix_ok && !push) begin
            pack_q[pix_idx*PIX_W +: PIX_W] <= video.data;
        end
    end

    //////////////////////////////////////////////////
    // first-word-fall-through FIFO
    //////////////////////////////////////////////////

    assign pop      = wdata_req_ch && (fifo_cnt != '0);
    assign burst_in = push && (wr_beat == BEAT_W'(BURST_WORDS - 1));
    assign wdata_ch = fifo_mem[rd_ptr];         // head word always shown

    always_ff @(posedge ddr_clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= {video.data, pack_q};   // last pixel on top
        end
    end

    always_ff @(posedge ddr_clk) begin
        if (!ddr_rstn || clr) begin
            pix_idx  <= '0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
            wr_beat  <= '0;
        end else begin
            if (pix_ok) begin
                pix_idx <= push ? '0 : pix_idx + 1'b1;
            end
            if (push) begin
                wr_ptr  <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                wr_beat <= burst_in ? '0 : wr_beat + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
                2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt;  // idle or both
            endcase
        end
    end

    //////////////////////////////////////////////////
    // burst request and position
    //////////////////////////////////////////////////

    assign retire    = wdone_ch && sending;
    assign wreq_ch   = (burst_cnt != '0) && !sending;
    assign col_nxt   = col_q + COL_STEP;
    assign col_wrap  = (col_nxt >= layout.h_num);           // end of window line
    assign line_wrap = (line_q + 1'b1 >= layout.v_num);     // end of window

    always_ff @(posedge ddr_clk) begin
        if (!ddr_rstn || clr) begin
            burst_cnt <= '0;
            sending   <= 1'b0;
            col_q     <= '0;
            line_q    <= '0;
        end else begin
            case ({burst_in, retire})
                2'b10:   burst_cnt <= burst_cnt + 1'b1;
                2'b01:   burst_cnt <= burst_cnt - 1'b1;
                default: burst_cnt <= burst_cnt;
            endcase
            if (retire) begin
                sending <= 1'b0;
            end else if (wdata_req_ch && (burst_cnt != '0)) begin
                sending <= 1'b1;                // first beat taken
            end
            if (retire) begin
                col_q <= col_wrap ? '0 : col_nxt;
                if (col_wrap) begin
                    line_q <= line_wrap ? '0 : line_q + 1'b1;
                end
            end
        end
    end

    assign cmd_rel.addr = addr_t'(line_q) * addr_t'(H_ACT) + addr_t'(col_q);
    assign cmd_rel.len  = len_t'(BURST_WORDS);

endmodule

/* rtl/write_arbiter.sv */
module write_arbiter
    import fb_pkg::*;
#(
    parameter int BURST_WORDS = 4               // beats per command
) (
    input  logic                   ddr_clk,
    input  logic                   ddr_rstn,
    input  logic    [NUM_CH-1:0]   wreq_ch,
    input  wr_cmd_t [NUM_CH-1:0]   cmd_rel,
    input  word_t   [NUM_CH-1:0]   wdata_ch,
    input  addr_t   [NUM_CH-1:0]   offset,      // window origin per channel
    input  logic                   wdata_req,   // from controller
    input  logic                   wdone,       // from controller
    output logic                   wreq,
    output wr_cmd_t                wcmd,
    output word_t                  wdata,
    output logic    [NUM_CH-1:0]   wdata_req_ch,
    output logic    [NUM_CH-1:0]   wdone_ch
);

    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_t;

    localparam int BEAT_W = $clog2(BURST_WORDS + 1);

    arb_state_t        state_q;
    arb_state_t        state_nxt;
    logic [NUM_CH-1:0] grant_q;                 // one-hot winner
    logic [NUM_CH-1:0] pick;                    // lowest requester
    logic [BEAT_W-1:0] beat_cnt;                // words passed to winner
    logic              beat_ok;

    //////////////////////////////////////////////////
    // idle / busy FSM and grant
    //////////////////////////////////////////////////

    assign pick = wreq_ch & (~wreq_ch + 1'b1);  // isolate lowest set bit

    always_comb begin
        state_nxt = state_q;
        case (state_q)
            ARB_IDLE: if (|wreq_ch) state_nxt = ARB_BUSY;
            ARB_BUSY: if (wdone) state_nxt = ARB_IDLE;
            default:  state_nxt = ARB_IDLE;
        endcase
    end

    always_ff @(posedge ddr_clk) begin
        if (!ddr_rstn) begin
            state_q  <= ARB_IDLE;
            grant_q  <= '0;
            beat_cnt <= '0;
        end else begin
            state_q <= state_nxt;
            if (state_q == ARB_IDLE) begin
                grant_q  <= pick;               // same edge as busy entry
                beat_cnt <= '0;
            end else if (wdone) begin
                grant_q  <= '0;                 // free for next round
                beat_cnt <= '0;
            end else if (wdata_req && beat_ok) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // command mux and strobe return
    //////////////////////////////////////////////////

    assign beat_ok = (beat_cnt != BEAT_W'(BURST_WORDS));    // no pops past the burst

    always_comb begin
        wreq  = 1'b0;
        wcmd  = '0;
        wdata = '0;
        for (int i = 0; i < NUM_CH; i++) begin
            if (grant_q[i]) begin
                wreq      = wreq_ch[i];
                wcmd.addr = cmd_rel[i].addr + offset[i];    // place in window
                wcmd.len  = cmd_rel[i].len;
                wdata     = wdata_ch[i];
            end
        end
    end

    assign wdata_req_ch = grant_q & {NUM_CH{wdata_req & beat_ok}};  // winner only
    assign wdone_ch     = grant_q & {NUM_CH{wdone}};

endmodule

/* rtl/frame_writer_top.sv */
module frame_writer_top
    import fb_pkg::*;
#(
    parameter int H_ACT       = 1280,           // frame width, pixels
    parameter int V_ACT       = 720,            // frame height, lines
    parameter int BURST_WORDS = 4,              // words per write burst
    parameter int FIFO_BURSTS = 2               // bursts buffered per channel
) (
    input  logic                    ddr_clk,
    input  logic                    ddr_rstn,
    input  mode_t                   mode,
    input  video_in_t [NUM_CH-1:0]  video_in,
    input  logic                    wdata_req,
    input  logic                    wdone,
    output logic                    wreq,
    output wr_cmd_t                 wcmd,
    output word_t                   wdata
);

    chan_layout_t [NUM_CH-1:0] layout;          // per channel placement
    addr_t        [NUM_CH-1:0] offset;          // window origins to arbiter
    logic         [NUM_CH-1:0] wreq_ch;
    wr_cmd_t      [NUM_CH-1:0] cmd_rel;         // window relative commands
    word_t        [NUM_CH-1:0] wdata_ch;        // FIFO head words
    logic         [NUM_CH-1:0] wdata_req_ch;
    logic         [NUM_CH-1:0] wdone_ch;

    //////////////////////////////////////////////////
    // placement
    //////////////////////////////////////////////////

    layout_decoder #(
        .H_ACT    (H_ACT),
        .V_ACT    (V_ACT)
    ) u_layout (
        .ddr_clk  (ddr_clk),
        .ddr_rstn (ddr_rstn),
        .mode     (mode),
        .layout   (layout)
    );

    //////////////////////////////////////////////////
    // per channel packing and bursts
    //////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        assign offset[i] = layout[i].offset;

        channel_writer #(
            .H_ACT        (H_ACT),
            .BURST_WORDS  (BURST_WORDS),
            .FIFO_BURSTS  (FIFO_BURSTS)
        ) u_chan (
            .ddr_clk      (ddr_clk),
            .ddr_rstn     (ddr_rstn),
            .video        (video_in[i]),
            .layout       (layout[i]),
            .wdata_req_ch (wdata_req_ch[i]),
            .wdone_ch     (wdone_ch[i]),
            .wreq_ch      (wreq_ch[i]),
            .cmd_rel      (cmd_rel[i]),
            .wdata_ch     (wdata_ch[i])
        );
    end

    //////////////////////////////////////////////////
    // shared write port
    //////////////////////////////////////////////////

    write_arbiter #(
        .BURST_WORDS  (BURST_WORDS)
    ) u_arb (
        .ddr_clk      (ddr_clk),
        .ddr_rstn     (ddr_rstn),
        .wreq_ch      (wreq_ch),
        .cmd_rel      (cmd_rel),
        .wdata_ch     (wdata_ch),
        .offset       (offset),
        .wdata_req    (wdata_req),
        .wdone        (wdone),
        .wreq         (wreq),
        .wcmd         (wcmd),
        .wdata        (wdata),
        .wdata_req_ch (wdata_req_ch),
        .wdone_ch     (wdone_ch)
    );

endmodule

/* verif/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int PERIOD     = 4,               // clock period, time units
    parameter int RST_CYCLES = 8                // cycles held in reset
) (
    output logic ddr_clk,
    output logic ddr_rstn
);

    initial begin
        ddr_clk = 1'b0;
        forever #(PERIOD / 2) ddr_clk = ~ddr_clk;
    end

    initial begin
        ddr_rstn <= 1'b0;                       // active low from time zero
        repeat (RST_CYCLES) @(posedge ddr_clk);
        ddr_rstn <= 1'b1;                       // released on a rising edge
    end

endmodule

/* verif/tb_frame_writer.sv */
module tb_frame_writer
    import fb_pkg::*;
();

    localparam int H_ACT       = 64;
    localparam int V_ACT       = 8;
    localparam int BURST_WORDS = 4;
    localparam int FIFO_BURSTS = 2;
    localparam int MEM_PIX     = H_ACT * V_ACT;             // frame memory, pixels
    localparam int BURST_PIX   = BURST_WORDS * PIX_PER_WORD;
    localparam int PIX_GAP     = 4;             // cycles per pixel
    localparam int MAX_DLY     = 3;             // worst controller answer delay
    localparam int QUIET_CYC   = 16;            // idle cycles that end a test
    localparam int MARGIN      = 2000;

    typedef struct {
        string             name;
        mode_t             mode;
        logic [NUM_CH-1:0] mask;                // channels that send video
        int                lines;
        int                fsync_at;            // line of mid-frame fsync, 0 none
        logic              chk_order;
    } row_t;

    logic                   ddr_clk;
    logic                   ddr_rstn;
    mode_t                  mode;
    video_in_t [NUM_CH-1:0] video_in;
    logic                   wdata_req;
    logic                   wdone;
    logic                   wreq;
    wr_cmd_t                wcmd;
    word_t                  wdata;

    row_t        rows [$];
    addr_t       cmd_log [$];                   // command addresses in order
    pix_t        mem [MEM_PIX];                 // controller memory
    pix_t        exp_mem [MEM_PIX];             // expected image
    int          exp_col [NUM_CH];
    int          exp_line [NUM_CH];
    int          exp_bpix [NUM_CH];             // pixels into current burst
    int          exp_cmds;
    int          errors = 0;
    logic        ctrl_busy;
    logic [31:0] pix_seed = 32'd74;
    string       cur_name;
    mode_t       cur_mode;

    tb_clock_gen #(.PERIOD(4), .RST_CYCLES(8)) clk_gen (
        .ddr_clk  (ddr_clk),
        .ddr_rstn (ddr_rstn)
    );

    frame_writer_top #(
        .H_ACT       (H_ACT),
        .V_ACT       (V_ACT),
        .BURST_WORDS (BURST_WORDS),
        .FIFO_BURSTS (FIFO_BURSTS)
    ) dut (
        .ddr_clk   (ddr_clk),
        .ddr_rstn  (ddr_rstn),
        .mode      (mode),
        .video_in  (video_in),
        .wdata_req (wdata_req),
        .wdone     (wdone),
        .wreq      (wreq),
        .wcmd      (wcmd),
        .wdata     (wdata)
    );

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic pix_t fill_pix(input int a);
        return pix_t'(a) ^ 16'hc3c3;            // unique per address
    endfunction

    function automatic logic win_on(input mode_t m, input int c);
        if (m == MODE_QUAD) return 1'b1;
        if ($countones(m) == 1) return m[3 - c];            // single0 is bit 3
        return 1'b0;
    endfunction

    function automatic int win_w(input mode_t m);
        return (m == MODE_QUAD) ? H_ACT / 2 : H_ACT;
    endfunction

    function automatic int win_h(input mode_t m);
        return (m == MODE_QUAD) ? V_ACT / 2 : V_ACT;
    endfunction

    function automatic int win_offset(input mode_t m, input int c);
        if (m != MODE_QUAD) return 0;
        return (c / 2) * (V_ACT / 2) * H_ACT + (c % 2) * (H_ACT / 2);
    endfunction

    function automatic int window_of(input addr_t a);
        int row;
        int col;
        row = int'(a) / H_ACT;
        col = int'(a) % H_ACT;
        return ((row >= V_ACT / 2) ? 2 : 0) + ((col >= H_ACT / 2) ? 1 : 0);
    endfunction

    function automatic int timeout_cycles();
        int pix;
        pix = 0;
        foreach (rows[i]) begin
            pix += $countones(rows[i].mask) * rows[i].lines * win_w(rows[i].mode);
        end
        return pix * (PIX_GAP + MAX_DLY) + MARGIN;
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s: expected %0h, actual %0h", what, exp, act);
        end
    endtask

    task automatic add_row(input string name, input mode_t m, input logic [NUM_CH-1:0] mask,
                           input int lines, input int fsync_at, input logic chk_order);
        row_t r;
        r.name      = name;
        r.mode      = m;
        r.mask      = mask;
        r.lines     = lines;
        r.fsync_at  = fsync_at;
        r.chk_order = chk_order;
        rows.push_back(r);
    endtask

    // expected placement of one accepted pixel
    task automatic model_pixel(input int c, input pix_t px);
        int a;
        if (win_on(cur_mode, c)) begin
            a = win_offset(cur_mode, c) + exp_line[c] * H_ACT + exp_col[c];
            exp_mem[a] = px;
            exp_col[c]++;
            if (exp_col[c] == win_w(cur_mode)) begin
                exp_col[c]  = 0;                // next window line
                exp_line[c] = (exp_line[c] + 1 == win_h(cur_mode)) ? 0 : exp_line[c] + 1;
            end
            exp_bpix[c]++;
            if (exp_bpix[c] == BURST_PIX) begin
                exp_bpix[c] = 0;
                exp_cmds++;                     // one whole burst ready
            end
        end
    endtask

    task automatic store_word(input int base, input word_t w);
        for (int p = 0; p < PIX_PER_WORD; p++) begin
            if (base + p >= MEM_PIX) begin
                errors++;
                $display("write outside the frame at pixel address %0d in %s", base + p,
                         cur_name);
            end else begin
                mem[base + p] = w[p*PIX_W +: PIX_W];    // first pixel in low bits
            end
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    task automatic frame_start();
        video_in_t [NUM_CH-1:0] nxt;
        nxt = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            nxt[c].fsync = 1'b1;
            exp_col[c]   = 0;
            exp_line[c]  = 0;
            exp_bpix[c]  = 0;
        end
        @(posedge ddr_clk);
        video_in <= nxt;
        @(posedge ddr_clk);
        video_in <= '0;
    endtask

    task automatic send_pixels(input int lines, input int width, input logic [NUM_CH-1:0] mask);
        video_in_t [NUM_CH-1:0] nxt;
        for (int l = 0; l < lines * width; l++) begin
            nxt = '0;
            @(posedge ddr_clk);
            for (int c = 0; c < NUM_CH; c++) begin
                if (mask[c]) begin
                    pix_seed    = lcg_next(pix_seed);
                    nxt[c].en   = 1'b1;
                    nxt[c].data = pix_seed[31:16];
                    model_pixel(c, pix_seed[31:16]);
                end
            end
            video_in <= nxt;                    // all channels in lockstep
            @(posedge ddr_clk);
            video_in <= '0;
            repeat (PIX_GAP - 2) @(posedge ddr_clk);
        end
    endtask

    task automatic wait_quiet();
        int idle;
        idle = 0;
        while (idle < QUIET_CYC) begin
            @(posedge ddr_clk);
            idle = (wreq || ctrl_busy) ? 0 : idle + 1;
        end
    endtask

    task automatic run_row(input int i);
        int w;
        int mark;
        int first;
        w        = win_w(rows[i].mode);
        mark     = -1;
        first    = 0;
        cur_name = rows[i].name;
        cur_mode = rows[i].mode;
        for (int a = 0; a < MEM_PIX; a++) begin
            mem[a]     = fill_pix(a);
            exp_mem[a] = fill_pix(a);
        end
        cmd_log.delete();
        exp_cmds = 0;
        @(posedge ddr_clk);
        mode <= rows[i].mode;
        repeat (2) @(posedge ddr_clk);          // layout registered
        frame_start();
        if (rows[i].fsync_at > 0) begin
            send_pixels(rows[i].fsync_at, w, rows[i].mask);
            wait_quiet();                       // burst boundary
            mark = cmd_log.size();
            frame_start();
            send_pixels(rows[i].lines - rows[i].fsync_at, w, rows[i].mask);
        end else begin
            send_pixels(rows[i].lines, w, rows[i].mask);
        end
        wait_quiet();
        for (int a = 0; a < MEM_PIX; a++) begin
            check($sformatf("%s mem[%0d]", cur_name, a), 32'(exp_mem[a]), 32'(mem[a]));
        end
        check({cur_name, " cmd_count"}, 32'(exp_cmds), 32'(cmd_log.size()));
        if (rows[i].chk_order) begin
            if (cmd_log.size() < NUM_CH) begin
                errors++;
                $display("%s: only %0d commands seen, order not checked", cur_name,
                         cmd_log.size());
            end else begin
                for (int k = 0; k < NUM_CH; k++) begin
                    check({cur_name, " order"}, 32'(k), 32'(window_of(cmd_log[k])));
                end
            end
        end
        if (mark >= 0) begin
            for (int c = NUM_CH - 1; c >= 0; c--) begin
                if (rows[i].mask[c]) first = c;             // lowest sending channel
            end
            if (mark >= cmd_log.size()) begin
                errors++;
                $display("%s: no command after the mid-frame fsync", cur_name);
            end else begin
                check({cur_name, " fsync_addr"}, 32'(win_offset(cur_mode, first)),
                      32'(cmd_log[mark]));
            end
        end
    endtask

    //////////////////////////////////////////////////
    // memory controller model
    //////////////////////////////////////////////////

    initial begin : mem_ctrl
        logic [31:0] dly_seed;
        addr_t       base;
        int          dly;
        wdata_req <= 1'b0;
        wdone     <= 1'b0;
        ctrl_busy <= 1'b0;
        dly_seed  = 32'd74;
        forever begin
            @(posedge ddr_clk);
            if (ddr_rstn && wreq) begin
                base = wcmd.addr;
                ctrl_busy <= 1'b1;
                cmd_log.push_back(base);
                check({cur_name, " cmd_len"}, 32'(BURST_WORDS), 32'(wcmd.len));
                check({cur_name, " cmd_align"}, 32'(0), 32'(base[2:0]));
                dly_seed = lcg_next(dly_seed);
                dly      = int'(dly_seed[17:16]);   // 0 to MAX_DLY
                repeat (dly) @(posedge ddr_clk);
                wdata_req <= 1'b1;
                for (int b = 0; b < BURST_WORDS; b++) begin
                    @(posedge ddr_clk);
                    store_word(int'(base) + b * PIX_PER_WORD, wdata);
                    if (b == BURST_WORDS - 1) begin
                        wdata_req <= 1'b0;
                        wdone     <= 1'b1;      // pulse after last word
                    end
                end
                @(posedge ddr_clk);
                wdone     <= 1'b0;
                ctrl_busy <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // test table and run control
    //////////////////////////////////////////////////

    initial begin : main
        mode     <= '0;
        video_in <= '0;
        //      name          mode          mask     lines fsync order
        add_row("single0",    MODE_SINGLE0, 4'b1111, 8,    0,    1'b0);
        add_row("single1",    MODE_SINGLE1, 4'b1111, 8,    0,    1'b0);
        add_row("single2",    MODE_SINGLE2, 4'b1111, 8,    0,    1'b0);
        add_row("single3",    MODE_SINGLE3, 4'b1111, 8,    0,    1'b0);
        add_row("quad",       MODE_QUAD,    4'b1111, 4,    0,    1'b0);
        add_row("quad_order", MODE_QUAD,    4'b1111, 1,    0,    1'b1);
        add_row("no_onehot",  5'b01100,     4'b1111, 8,    0,    1'b0);
        add_row("fsync_mid",  MODE_QUAD,    4'b0100, 6,    2,    1'b0);
        @(posedge ddr_rstn);
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end
        $display("%0d tests run, %0d errors", rows.size(), errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        int cycles;
        @(posedge ddr_rstn);
        limit  = timeout_cycles();
        cycles = 0;
        while (cycles < limit) begin
            @(posedge ddr_clk);
            cycles++;
        end
        $display("timeout: run still going after %0d cycles", limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* list.f */
rtl/fb_pkg.sv
rtl/layout_decoder.sv
rtl/channel_writer.sv
rtl/write_arbiter.sv
rtl/frame_writer_top.sv
verif/tb_clock_gen.sv
verif/tb_frame_writer.sv

/* Makefile */
TOP = tb_frame_writer

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module $(TOP) -f list.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
